// ==== hdl/ccu_pkg.sv ====
package ccu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned NoMasters       = 2;
  localparam int unsigned MstSelWidth     = 1;
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned DataWidth       = 32;
  localparam int unsigned MstIdWidth      = 2;
  localparam int unsigned LenWidth        = 4;
  localparam int unsigned OpWidth         = 4;
  localparam int unsigned CmAddrBase      = 6;
  localparam int unsigned CmAddrWidth     = 26;
  localparam int unsigned TrackerDepth    = 4;
  localparam int unsigned TrackerIdxWidth = $clog2(TrackerDepth);

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [OpWidth-1:0] {
    READ_NO_SNOOP = 4'd0,
    READ_ONCE     = 4'd1,
    READ_SHARED   = 4'd2,
    READ_UNIQUE   = 4'd3,
    CLEAN_UNIQUE  = 4'd4,
    MAKE_UNIQUE   = 4'd5
  } ar_op_e;

  typedef enum logic {
    LANE_NOSNOOP = 1'b0,
    LANE_SNOOP   = 1'b1
  } lane_e;

  typedef enum logic [1:0] {
    FREE,
    WAIT_R,
    WAIT_ACK
  } entry_state_e;

  ////////////////////
  // Channels
  ////////////////////

  typedef logic [CmAddrWidth-1:0]     cm_addr_t;
  typedef logic [TrackerIdxWidth-1:0] trk_idx_t;

  typedef struct packed {
    logic [MstIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [LenWidth-1:0]   len;
    ar_op_e                op;
  } mst_ar_t;

  // Route tag travels in the memory ID
  typedef struct packed {
    lane_e                  lane;
    logic [MstSelWidth-1:0] master;
    logic [MstIdWidth-1:0]  id;
  } route_t;

  typedef struct packed {
    route_t               route;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
    ar_op_e               op;
  } ar_req_t;

  typedef struct packed {
    logic [MstIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic                  last;
  } mst_r_t;

  typedef struct packed {
    route_t               route;
    logic [DataWidth-1:0] data;
    logic                 last;
  } mem_r_t;

endpackage

// ==== hdl/ccu_read_decoder.sv ====
`timescale 1ns/1ps

module ccu_read_decoder (
  input  logic             ar_valid_i,
  input  ccu_pkg::mst_ar_t ar_i,
  output logic             ar_ready_o,
  output logic [1:0]       lane_valid_o,
  input  logic [1:0]       lane_ready_i
);

  ccu_pkg::lane_e lane;

  // Opcode to lane
  always_comb begin
    case (ar_i.op)
      ccu_pkg::READ_NO_SNOOP: begin
        lane = ccu_pkg::LANE_NOSNOOP;
      end
      ccu_pkg::READ_ONCE,
      ccu_pkg::READ_SHARED,
      ccu_pkg::READ_UNIQUE,
      ccu_pkg::CLEAN_UNIQUE,
      ccu_pkg::MAKE_UNIQUE: begin
        lane = ccu_pkg::LANE_SNOOP;
      end
      // Unknown codes take the coherent path
      default: begin
        lane = ccu_pkg::LANE_SNOOP;
      end
    endcase
  end

  // Handshake follows the chosen lane only
  always_comb begin
    lane_valid_o       = 2'b00;
    lane_valid_o[lane] = ar_valid_i;
    ar_ready_o         = lane_ready_i[lane];
  end

endmodule

// ==== hdl/ccu_rr_arbiter.sv ====
`timescale 1ns/1ps

module ccu_rr_arbiter (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [1:0]             req_valid_i,
  input  ccu_pkg::ar_req_t [1:0] req_i,
  output logic [1:0]             req_ready_o,
  output logic                   out_valid_o,
  output ccu_pkg::ar_req_t       out_o,
  input  logic                   out_ready_i,
  output logic                   grant_o
);

  logic prio_q;
  logic lock_q;
  logic grant_q;
  logic grant;

  // Locked grant wins, then priority input, then the other one
  always_comb begin
    if (lock_q) begin
      grant = grant_q;
    end else if (req_valid_i[prio_q]) begin
      grant = prio_q;
    end else if (req_valid_i[~prio_q]) begin
      grant = ~prio_q;
    end else begin
      grant = prio_q;
    end
  end

  always_comb begin
    out_valid_o        = req_valid_i[grant];
    out_o              = req_i[grant];
    req_ready_o        = 2'b00;
    req_ready_o[grant] = out_ready_i;
    grant_o            = grant;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q  <= 1'b0;
      lock_q  <= 1'b0;
      grant_q <= 1'b0;
    end else begin
      // Hold the grant while the output is stalled
      lock_q  <= out_valid_o && !out_ready_i;
      grant_q <= grant;
      if (out_valid_o && out_ready_i) begin
        prio_q <= ~grant;
      end
    end
  end

endmodule

// ==== hdl/ccu_line_tracker.sv ====
`timescale 1ns/1ps

module ccu_line_tracker (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       alloc_i,
  input  ccu_pkg::ar_req_t                           alloc_req_i,
  output logic                                       can_accept_o,
  input  logic                                       r_fire_i,
  input  ccu_pkg::mem_r_t                            r_beat_i,
  input  logic [ccu_pkg::NoMasters-1:0]              rack_i,
  output logic [ccu_pkg::NoMasters-1:0]              cm_req_o,
  output ccu_pkg::cm_addr_t [ccu_pkg::NoMasters-1:0] cm_addr_o
);

  ccu_pkg::entry_state_e state_q [ccu_pkg::TrackerDepth];
  ccu_pkg::route_t       route_q [ccu_pkg::TrackerDepth];
  ccu_pkg::cm_addr_t     line_q  [ccu_pkg::TrackerDepth];

  // Per-master queue of completed entries in last-beat order
  ccu_pkg::trk_idx_t cpl_idx_q [ccu_pkg::NoMasters][ccu_pkg::TrackerDepth];
  ccu_pkg::trk_idx_t cpl_wr_q  [ccu_pkg::NoMasters];
  ccu_pkg::trk_idx_t cpl_rd_q  [ccu_pkg::NoMasters];
  ccu_pkg::trk_idx_t pop_idx   [ccu_pkg::NoMasters];

  logic [ccu_pkg::NoMasters-1:0]              cm_req_q;
  ccu_pkg::cm_addr_t [ccu_pkg::NoMasters-1:0] cm_addr_q;

  logic              free_found;
  logic              id_hit;
  logic              beat_hit;
  ccu_pkg::trk_idx_t free_idx;
  ccu_pkg::trk_idx_t beat_idx;

  ////////////////////
  // Lookup
  ////////////////////

  // Downward scan so the lowest index wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    id_hit     = 1'b0;
    beat_hit   = 1'b0;
    beat_idx   = '0;
    for (int i = ccu_pkg::TrackerDepth - 1; i >= 0; i--) begin
      if (state_q[i] == ccu_pkg::FREE) begin
        free_found = 1'b1;
        free_idx   = ccu_pkg::trk_idx_t'(i);
      end
      if (state_q[i] == ccu_pkg::WAIT_R &&
          route_q[i].master == alloc_req_i.route.master &&
          route_q[i].id == alloc_req_i.route.id) begin
        id_hit = 1'b1;
      end
      if (state_q[i] == ccu_pkg::WAIT_R &&
          route_q[i].master == r_beat_i.route.master &&
          route_q[i].id == r_beat_i.route.id) begin
        beat_hit = 1'b1;
        beat_idx = ccu_pkg::trk_idx_t'(i);
      end
    end
  end

  always_comb begin
    for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
      pop_idx[m] = cpl_idx_q[m][cpl_rd_q[m]];
    end
  end

  assign can_accept_o = free_found && !id_hit;
  assign cm_req_o     = cm_req_q;
  assign cm_addr_o    = cm_addr_q;

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < ccu_pkg::TrackerDepth; i++) begin
        state_q[i] <= ccu_pkg::FREE;
      end
      for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
        cpl_wr_q[m] <= '0;
        cpl_rd_q[m] <= '0;
      end
      cm_req_q <= '0;
    end else begin
      if (alloc_i) begin
        state_q[free_idx] <= ccu_pkg::WAIT_R;
      end
      if (r_fire_i && r_beat_i.last && beat_hit) begin
        state_q[beat_idx]                <= ccu_pkg::WAIT_ACK;
        cpl_wr_q[r_beat_i.route.master] <= cpl_wr_q[r_beat_i.route.master] + 1'b1;
      end
      for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
        cm_req_q[m] <= rack_i[m];
        if (rack_i[m]) begin
          state_q[pop_idx[m]] <= ccu_pkg::FREE;
          cpl_rd_q[m]         <= cpl_rd_q[m] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      route_q[free_idx] <= alloc_req_i.route;
      line_q[free_idx]  <= alloc_req_i.addr[ccu_pkg::CmAddrBase +: ccu_pkg::CmAddrWidth];
    end
    if (r_fire_i && r_beat_i.last && beat_hit) begin
      cpl_idx_q[r_beat_i.route.master][cpl_wr_q[r_beat_i.route.master]] <= beat_idx;
    end
    for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
      if (rack_i[m]) begin
        cm_addr_q[m] <= line_q[pop_idx[m]];
      end
    end
  end

endmodule

// ==== hdl/ccu_snoop_lane.sv ====
`timescale 1ns/1ps

module ccu_snoop_lane (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [1:0]                                 req_valid_i,
  input  ccu_pkg::ar_req_t [1:0]                     req_i,
  output logic [1:0]                                 req_ready_o,
  output logic                                       out_valid_o,
  output ccu_pkg::ar_req_t                           out_o,
  input  logic                                       out_ready_i,
  input  logic                                       r_fire_i,
  input  ccu_pkg::mem_r_t                            r_beat_i,
  input  logic [ccu_pkg::NoMasters-1:0]              rack_i,
  output logic [ccu_pkg::NoMasters-1:0]              cm_req_o,
  output ccu_pkg::cm_addr_t [ccu_pkg::NoMasters-1:0] cm_addr_o
);

  logic             arb_valid;
  logic             arb_ready;
  logic             arb_grant;
  logic             can_accept;
  ccu_pkg::ar_req_t arb_out;
  ccu_pkg::ar_req_t lane_req;

  ccu_rr_arbiter u_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .out_valid_o (arb_valid),
    .out_o       (arb_out),
    .out_ready_i (arb_ready),
    .grant_o     (arb_grant)
  );

  always_comb begin
    lane_req              = arb_out;
    lane_req.route.master = arb_grant;
  end

  // Stall toward memory while the tracker cannot take the read
  assign out_valid_o = arb_valid && can_accept;
  assign arb_ready   = out_ready_i && can_accept;
  assign out_o       = lane_req;

  ccu_line_tracker u_line_tracker (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .alloc_i      (out_valid_o && out_ready_i),
    .alloc_req_i  (lane_req),
    .can_accept_o (can_accept),
    .r_fire_i     (r_fire_i),
    .r_beat_i     (r_beat_i),
    .rack_i       (rack_i),
    .cm_req_o     (cm_req_o),
    .cm_addr_o    (cm_addr_o)
  );

endmodule

// ==== hdl/ccu_resp_router.sv ====
`timescale 1ns/1ps

module ccu_resp_router (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     mem_r_valid_i,
  input  ccu_pkg::mem_r_t                          mem_r_i,
  output logic                                     mem_r_ready_o,
  output logic [ccu_pkg::NoMasters-1:0]            r_valid_o,
  output ccu_pkg::mst_r_t [ccu_pkg::NoMasters-1:0] r_o,
  input  logic [ccu_pkg::NoMasters-1:0]            r_ready_i,
  output logic                                     snoop_fire_o,
  output ccu_pkg::mem_r_t                          snoop_beat_o
);

  logic [ccu_pkg::NoMasters-1:0]            valid_q;
  ccu_pkg::mst_r_t [ccu_pkg::NoMasters-1:0] r_q;
  logic [ccu_pkg::NoMasters-1:0]            slot_free;
  logic [ccu_pkg::MstSelWidth-1:0]          target;
  logic                                     mem_fire;

  // Slot can take a beat when empty or draining this cycle
  assign slot_free     = ~valid_q | r_ready_i;
  assign target        = mem_r_i.route.master;
  assign mem_r_ready_o = slot_free[target];
  assign mem_fire      = mem_r_valid_i && mem_r_ready_o;

  assign snoop_fire_o = mem_fire && (mem_r_i.route.lane == ccu_pkg::LANE_SNOOP);
  assign snoop_beat_o = mem_r_i;

  assign r_valid_o = valid_q;
  assign r_o       = r_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
        if (mem_fire && target == m) begin
          valid_q[m] <= 1'b1;
        end else if (r_ready_i[m]) begin
          valid_q[m] <= 1'b0;
        end
      end
    end
  end

  // Route collapses back to the master's own id
  always_ff @(posedge clk_i) begin
    for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
      if (mem_fire && target == m) begin
        r_q[m].id   <= mem_r_i.route.id;
        r_q[m].data <= mem_r_i.data;
        r_q[m].last <= mem_r_i.last;
      end
    end
  end

endmodule

// ==== hdl/ccu_master_path.sv ====
`timescale 1ns/1ps

module ccu_master_path (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [ccu_pkg::NoMasters-1:0]              ar_valid_i,
  input  ccu_pkg::mst_ar_t [ccu_pkg::NoMasters-1:0]  ar_i,
  output logic [ccu_pkg::NoMasters-1:0]              ar_ready_o,
  output logic [ccu_pkg::NoMasters-1:0]              r_valid_o,
  output ccu_pkg::mst_r_t [ccu_pkg::NoMasters-1:0]   r_o,
  input  logic [ccu_pkg::NoMasters-1:0]              r_ready_i,
  input  logic [ccu_pkg::NoMasters-1:0]              rack_i,
  output logic                                       mem_ar_valid_o,
  output ccu_pkg::ar_req_t                           mem_ar_o,
  input  logic                                       mem_ar_ready_i,
  input  logic                                       mem_r_valid_i,
  input  ccu_pkg::mem_r_t                            mem_r_i,
  output logic                                       mem_r_ready_o,
  output logic [ccu_pkg::NoMasters-1:0]              cm_req_o,
  output ccu_pkg::cm_addr_t [ccu_pkg::NoMasters-1:0] cm_addr_o
);

  logic [1:0] dec_valid [ccu_pkg::NoMasters];
  logic [1:0] dec_ready [ccu_pkg::NoMasters];

  ccu_pkg::ar_req_t [ccu_pkg::NoMasters-1:0] lane_req;
  logic [ccu_pkg::NoMasters-1:0]             snoop_valid, snoop_ready;
  logic [ccu_pkg::NoMasters-1:0]             nosnoop_valid, nosnoop_ready;

  logic             snoop_out_valid, snoop_out_ready;
  logic             nosnoop_out_valid, nosnoop_out_ready;
  logic             nosnoop_grant;
  ccu_pkg::ar_req_t snoop_out, nosnoop_arb_out, nosnoop_out;

  logic [1:0]             mem_req_valid, mem_req_ready;
  ccu_pkg::ar_req_t [1:0] mem_req;
  ccu_pkg::ar_req_t       mem_arb_out;
  logic                   mem_grant;

  logic            snoop_fire;
  ccu_pkg::mem_r_t snoop_beat;

  ////////////////////
  // Decode
  ////////////////////

  ccu_read_decoder u_decoder_0 (
    .ar_valid_i   (ar_valid_i[0]),
    .ar_i         (ar_i[0]),
    .ar_ready_o   (ar_ready_o[0]),
    .lane_valid_o (dec_valid[0]),
    .lane_ready_i (dec_ready[0])
  );

  ccu_read_decoder u_decoder_1 (
    .ar_valid_i   (ar_valid_i[1]),
    .ar_i         (ar_i[1]),
    .ar_ready_o   (ar_ready_o[1]),
    .lane_valid_o (dec_valid[1]),
    .lane_ready_i (dec_ready[1])
  );

  // Master field is filled after arbitration
  always_comb begin
    for (int m = 0; m < ccu_pkg::NoMasters; m++) begin
      lane_req[m].route.lane   = ccu_pkg::LANE_NOSNOOP;
      lane_req[m].route.master = '0;
      lane_req[m].route.id     = ar_i[m].id;
      lane_req[m].addr         = ar_i[m].addr;
      lane_req[m].len          = ar_i[m].len;
      lane_req[m].op           = ar_i[m].op;
      snoop_valid[m]           = dec_valid[m][ccu_pkg::LANE_SNOOP];
      nosnoop_valid[m]         = dec_valid[m][ccu_pkg::LANE_NOSNOOP];
      dec_ready[m][ccu_pkg::LANE_SNOOP]   = snoop_ready[m];
      dec_ready[m][ccu_pkg::LANE_NOSNOOP] = nosnoop_ready[m];
    end
  end

  ////////////////////
  // Lanes
  ////////////////////

  ccu_snoop_lane u_snoop_lane (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (snoop_valid),
    .req_i       (lane_req),
    .req_ready_o (snoop_ready),
    .out_valid_o (snoop_out_valid),
    .out_o       (snoop_out),
    .out_ready_i (snoop_out_ready),
    .r_fire_i    (snoop_fire),
    .r_beat_i    (snoop_beat),
    .rack_i      (rack_i),
    .cm_req_o    (cm_req_o),
    .cm_addr_o   (cm_addr_o)
  );

  ccu_rr_arbiter u_nosnoop_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (nosnoop_valid),
    .req_i       (lane_req),
    .req_ready_o (nosnoop_ready),
    .out_valid_o (nosnoop_out_valid),
    .out_o       (nosnoop_arb_out),
    .out_ready_i (nosnoop_out_ready),
    .grant_o     (nosnoop_grant)
  );

  always_comb begin
    nosnoop_out              = nosnoop_arb_out;
    nosnoop_out.route.master = nosnoop_grant;
  end

  ////////////////////
  // Memory port
  ////////////////////

  assign mem_req_valid[ccu_pkg::LANE_SNOOP]   = snoop_out_valid;
  assign mem_req_valid[ccu_pkg::LANE_NOSNOOP] = nosnoop_out_valid;
  assign mem_req[ccu_pkg::LANE_SNOOP]         = snoop_out;
  assign mem_req[ccu_pkg::LANE_NOSNOOP]       = nosnoop_out;
  assign snoop_out_ready   = mem_req_ready[ccu_pkg::LANE_SNOOP];
  assign nosnoop_out_ready = mem_req_ready[ccu_pkg::LANE_NOSNOOP];

  ccu_rr_arbiter u_mem_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .req_ready_o (mem_req_ready),
    .out_valid_o (mem_ar_valid_o),
    .out_o       (mem_arb_out),
    .out_ready_i (mem_ar_ready_i),
    .grant_o     (mem_grant)
  );

  always_comb begin
    mem_ar_o            = mem_arb_out;
    mem_ar_o.route.lane = ccu_pkg::lane_e'(mem_grant);
  end

  ccu_resp_router u_resp_router (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_r_i       (mem_r_i),
    .mem_r_ready_o (mem_r_ready_o),
    .r_valid_o     (r_valid_o),
    .r_o           (r_o),
    .r_ready_i     (r_ready_i),
    .snoop_fire_o  (snoop_fire),
    .snoop_beat_o  (snoop_beat)
  );

endmodule

// ==== tests/ccu_mem_model.sv ====
`timescale 1ns/1ps

module ccu_mem_model (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             run_i,
  input  logic             mem_ar_valid_i,
  input  ccu_pkg::ar_req_t mem_ar_i,
  output logic             mem_ar_ready_o,
  output logic             mem_r_valid_o,
  output ccu_pkg::mem_r_t  mem_r_o,
  input  logic             mem_r_ready_i,
  output int               beats_sent_o
);

  integer           seed;
  ccu_pkg::ar_req_t req_q [$];
  int               beat;
  logic             r_taken;

  initial begin
    seed           = 32'hbe49;
    beat           = 0;
    r_taken        = 1'b0;
    beats_sent_o   = 0;
    mem_ar_ready_o = 1'b0;
    mem_r_valid_o  = 1'b0;
    mem_r_o        = '0;
  end

  // Handshakes are only recorded on the rising edge
  always @(posedge clk_i) begin
    if (mem_ar_valid_i && mem_ar_ready_o) begin
      req_q.push_back(mem_ar_i);
    end
    if (mem_r_valid_o && mem_r_ready_i) begin
      r_taken = 1'b1;
    end
  end

  always @(negedge clk_i) begin
    if (reset_i || !run_i) begin
      mem_ar_ready_o = 1'b0;
      mem_r_valid_o  = 1'b0;
    end else begin
      if (r_taken) begin
        r_taken       = 1'b0;
        mem_r_valid_o = 1'b0;
        beats_sent_o  = beats_sent_o + 1;
        if (mem_r_o.last) begin
          void'(req_q.pop_front());
          beat = 0;
        end else begin
          beat = beat + 1;
        end
      end
      mem_ar_ready_o = ($random(seed) & 3) != 0;
      // In-order replies with one beat per offer
      if (!mem_r_valid_o && req_q.size() > 0 && ($random(seed) & 1) != 0) begin
        mem_r_o.route = req_q[0].route;
        mem_r_o.data  = req_q[0].addr + ccu_pkg::AddrWidth'(beat);
        mem_r_o.last  = (beat == int'(req_q[0].len));
        mem_r_valid_o = 1'b1;
      end
    end
  end

endmodule

// ==== tests/tb_ccu_master_path.sv ====
`timescale 1ns/1ps

module tb_ccu_master_path;

  localparam int NoReads       = 300;
  localparam int TimeoutCycles = NoReads * 2 * 40;

  logic                                       clk_i;
  logic                                       reset_i;
  logic                                       run;
  logic [ccu_pkg::NoMasters-1:0]              ar_valid_i;
  ccu_pkg::mst_ar_t [ccu_pkg::NoMasters-1:0]  ar_i;
  logic [ccu_pkg::NoMasters-1:0]              ar_ready_o;
  logic [ccu_pkg::NoMasters-1:0]              r_valid_o;
  ccu_pkg::mst_r_t [ccu_pkg::NoMasters-1:0]   r_o;
  logic [ccu_pkg::NoMasters-1:0]              r_ready_i;
  logic [ccu_pkg::NoMasters-1:0]              rack_i;
  logic                                       mem_ar_valid_o;
  ccu_pkg::ar_req_t                           mem_ar_o;
  logic                                       mem_ar_ready_i;
  logic                                       mem_r_valid_i;
  ccu_pkg::mem_r_t                            mem_r_i;
  logic                                       mem_r_ready_o;
  logic [ccu_pkg::NoMasters-1:0]              cm_req_o;
  ccu_pkg::cm_addr_t [ccu_pkg::NoMasters-1:0] cm_addr_o;
  int                                         beats_sent;

  // Reference model state
  integer            seed;
  int                cycles;
  int                launched [2];
  logic              accepted [2];
  logic              busy [2][4];
  ccu_pkg::mst_ar_t  mem_order [2][$];
  int                beat_idx [2];
  ccu_pkg::cm_addr_t rack_pend [2][$];
  logic              cm_expect [2];
  ccu_pkg::cm_addr_t cm_line [2];
  int                inflight;
  int                beats_expected;
  int                beats_recv;

  ccu_master_path u_ccu_master_path (.*);

  ccu_mem_model u_mem_model (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .run_i          (run),
    .mem_ar_valid_i (mem_ar_valid_o),
    .mem_ar_i       (mem_ar_o),
    .mem_ar_ready_o (mem_ar_ready_i),
    .mem_r_valid_o  (mem_r_valid_i),
    .mem_r_o        (mem_r_i),
    .mem_r_ready_i  (mem_r_ready_o),
    .beats_sent_o   (beats_sent)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////
  // Checks
  ////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_ar(input ccu_pkg::ar_req_t got, input ccu_pkg::ar_req_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: memory AR got %h expected %h",
                              $time, got, exp));
    end
  endtask

  task automatic check_r(input int m, input ccu_pkg::mst_r_t got,
                         input ccu_pkg::mst_r_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: master %0d R got %h expected %h",
                              $time, m, got, exp));
    end
  endtask

  task automatic check_cm(input int m, input logic got_req, input ccu_pkg::cm_addr_t got,
                          input logic exp_req, input ccu_pkg::cm_addr_t exp);
    if (got_req !== exp_req || (exp_req && got !== exp)) begin
      stop_on_error($sformatf("mismatch at %0t: master %0d cm_req %b line %h expected %b %h",
                              $time, m, got_req, got, exp_req, exp));
    end
  endtask

  task automatic check_idle();
    if (ar_ready_o !== '0 || r_valid_o !== '0 || cm_req_o !== '0 ||
        mem_ar_valid_o !== 1'b0) begin
      stop_on_error("outputs were not idle during or right after reset");
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  always @(negedge clk_i) begin
    int start;
    int id;
    if (run) begin
      for (int m = 0; m < 2; m++) begin
        if (accepted[m]) begin
          accepted[m]   = 1'b0;
          ar_valid_i[m] = 1'b0;
        end
        if (!ar_valid_i[m] && launched[m] < NoReads && rand_below(2) == 0) begin
          start = rand_below(4);
          id    = -1;
          for (int k = 0; k < 4; k++) begin
            if (id < 0 && !busy[m][(start + k) % 4]) begin
              id = (start + k) % 4;
            end
          end
          if (id >= 0) begin
            busy[m][id]   = 1'b1;
            ar_i[m].id    = ccu_pkg::MstIdWidth'(id);
            ar_i[m].addr  = $random(seed);
            ar_i[m].len   = ccu_pkg::LenWidth'(rand_below(16));
            ar_i[m].op    = ccu_pkg::ar_op_e'(ccu_pkg::OpWidth'(rand_below(6)));
            ar_valid_i[m] = 1'b1;
            launched[m]   = launched[m] + 1;
          end
        end
        r_ready_i[m] = rand_below(4) != 0;
        // Acknowledge completed coherent reads after a random wait
        rack_i[m] = rack_pend[m].size() > 0 && rand_below(3) == 0;
      end
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk_i) begin : monitor
    int                hs_cnt;
    int                hs_m;
    ccu_pkg::ar_req_t  exp_ar;
    ccu_pkg::mst_r_t   exp_r;
    ccu_pkg::mst_ar_t  rd;
    if (run) begin
      for (int m = 0; m < 2; m++) begin
        check_cm(m, cm_req_o[m], cm_addr_o[m], cm_expect[m], cm_line[m]);
        if (cm_expect[m]) begin
          inflight = inflight - 1;
        end
        cm_expect[m] = rack_i[m];
        if (rack_i[m]) begin
          cm_line[m] = rack_pend[m].pop_front();
        end
      end
      hs_cnt = 0;
      hs_m   = 0;
      for (int m = 0; m < 2; m++) begin
        if (ar_valid_i[m] && ar_ready_o[m]) begin
          hs_cnt      = hs_cnt + 1;
          hs_m        = m;
          accepted[m] = 1'b1;
        end
      end
      // The address path has no storage, so both handshakes coincide
      if ((mem_ar_valid_o && mem_ar_ready_i) != (hs_cnt == 1) || hs_cnt > 1) begin
        stop_on_error("master and memory address handshakes did not line up");
      end
      if (hs_cnt == 1) begin
        rd                  = ar_i[hs_m];
        exp_ar.route.lane   = (rd.op == ccu_pkg::READ_NO_SNOOP) ?
                              ccu_pkg::LANE_NOSNOOP : ccu_pkg::LANE_SNOOP;
        exp_ar.route.master = ccu_pkg::MstSelWidth'(hs_m);
        exp_ar.route.id     = rd.id;
        exp_ar.addr         = rd.addr;
        exp_ar.len          = rd.len;
        exp_ar.op           = rd.op;
        check_ar(mem_ar_o, exp_ar);
        mem_order[hs_m].push_back(rd);
        beats_expected = beats_expected + int'(rd.len) + 1;
        if (exp_ar.route.lane == ccu_pkg::LANE_SNOOP) begin
          inflight = inflight + 1;
        end
      end
      if (inflight > int'(ccu_pkg::TrackerDepth)) begin
        stop_on_error("more coherent reads in flight than the tracker holds");
      end
      for (int m = 0; m < 2; m++) begin
        if (r_valid_o[m] && r_ready_i[m]) begin
          if (mem_order[m].size() == 0) begin
            stop_on_error($sformatf("master %0d got a read beat it never asked for", m));
          end
          rd         = mem_order[m][0];
          exp_r.id   = rd.id;
          exp_r.data = rd.addr + ccu_pkg::DataWidth'(beat_idx[m]);
          exp_r.last = (beat_idx[m] == int'(rd.len));
          check_r(m, r_o[m], exp_r);
          beats_recv = beats_recv + 1;
          if (exp_r.last) begin
            rd          = mem_order[m].pop_front();
            beat_idx[m] = 0;
            busy[m][rd.id] = 1'b0;
            if (rd.op != ccu_pkg::READ_NO_SNOOP) begin
              rack_pend[m].push_back(rd.addr[ccu_pkg::CmAddrBase +: ccu_pkg::CmAddrWidth]);
            end
          end else begin
            beat_idx[m] = beat_idx[m] + 1;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > TimeoutCycles) begin
      $display("timeout after %0d cycles with reads still open", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int m = 0; m < 2; m++) begin
      if (launched[m] < NoReads || ar_valid_i[m] || mem_order[m].size() > 0 ||
          rack_pend[m].size() > 0 || cm_expect[m] || rack_i[m]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial begin
    seed           = 32'hbe49;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    run            = 1'b0;
    cycles         = 0;
    ar_valid_i     = '0;
    ar_i           = '0;
    r_ready_i      = '0;
    rack_i         = '0;
    inflight       = 0;
    beats_expected = 0;
    beats_recv     = 0;
    for (int m = 0; m < 2; m++) begin
      launched[m]  = 0;
      accepted[m]  = 1'b0;
      beat_idx[m]  = 0;
      cm_expect[m] = 1'b0;
      cm_line[m]   = '0;
      for (int i = 0; i < 4; i++) begin
        busy[m][i] = 1'b0;
      end
    end
    repeat (10) begin
      @(negedge clk_i);
      check_idle();
    end
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle();
    run <= 1'b1;
    while (!all_done()) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    if (beats_recv != beats_expected || beats_sent != beats_expected) begin
      $display("beat totals differ: expected %0d, memory sent %0d, masters got %0d",
               beats_expected, beats_sent, beats_recv);
      $display("TESTBENCH FAILED");
      $fatal(1, "beat totals");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
hdl/ccu_pkg.sv
hdl/ccu_read_decoder.sv
hdl/ccu_rr_arbiter.sv
hdl/ccu_line_tracker.sv
hdl/ccu_snoop_lane.sv
hdl/ccu_resp_router.sv
hdl/ccu_master_path.sv
tests/ccu_mem_model.sv
tests/tb_ccu_master_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_ccu_master_path \
  --Mdir obj_dir -o tb_sim \
  -f vlog.f

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
